//--- hw/vga_stream_defines.svh
// VGA 640x480 timing counts, flash read command, FIFO depth and base dummy cycles
`ifndef VGA_STREAM_DEFINES_SVH
`define VGA_STREAM_DEFINES_SVH

// Horizontal timing in pixel clocks
`define H_VISIBLE 640
`define H_FRONT 16
`define H_SYNC 96
`define H_TOTAL 800

// Vertical timing in lines
`define V_VISIBLE 480
`define V_FRONT 10
`define V_SYNC 2
`define V_TOTAL 525

`define FLASH_CMD_QREAD 8'h6B   // Quad output fast read
`define FIFO_DEPTH 4            // Instruction FIFO entries
`define DUMMY_BASE 4            // Dummy cycles at latency 0

`endif

//--- hw/vga_stream_pkg.sv
// Shared instruction, colour and field types and the QSPI reader state enum
package vga_stream_pkg;

    typedef logic [17:0] instr_t;       // EOL flag, run length, colour
    typedef logic [23:0] flash_word_t;  // Raw flash word, top 6 bits unused
    typedef logic [7:0]  colour_t;      // B[7:6] G[5:3] R[2:0]
    typedef logic [8:0]  run_len_t;     // Pixels minus one
    typedef logic [1:0]  latency_t;     // Latency pin setting
    typedef logic [3:0]  dummy_t;       // Flash dummy SCLK periods

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_CMD,
        ST_ADDR,
        ST_DUMMY,
        ST_DATA,
        ST_HANDOFF
    } qspi_state_t;

endpackage

//--- hw/stream_ctrl.sv
// Frame restart generator with the latched dummy-cycle setting
`include "vga_stream_defines.svh"

module stream_ctrl (
    input  logic                    clk,
    input  logic                    arst_n,
    input  vga_stream_pkg::latency_t latency,
    input  logic                    vsync_start,
    output logic                    restart,
    output vga_stream_pkg::dummy_t  dummy_cycles
);

    import vga_stream_pkg::*;

    logic started;      // Low until the first clock after reset
    dummy_t dummy_next;

    assign dummy_next = dummy_t'(`DUMMY_BASE) + {1'b0, latency, 1'b0};  // 4, 6, 8 or 10

    // One restart right after reset, then one per frame at the start of vsync
    assign restart = !started || vsync_start;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            started      <= 1'b0;
            dummy_cycles <= dummy_t'(`DUMMY_BASE);
        end else begin
            started <= 1'b1;
            if (restart) begin
                dummy_cycles <= dummy_next;  // Held for the whole frame
            end
        end
    end

endmodule

//--- hw/qspi_reader.sv
// QSPI quad-output flash reader with a four-phase word handoff
`include "vga_stream_defines.svh"

module qspi_reader (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        restart,
    input  vga_stream_pkg::dummy_t      dummy_cycles,
    output logic                        spi_sclk,
    output logic                        spi_cs_n,
    output logic [3:0]                  spi_io_out,
    output logic [3:0]                  spi_io_oe,
    input  logic [3:0]                  spi_io_in,
    output logic                        wr_req,
    input  logic                        wr_ack,
    output vga_stream_pkg::flash_word_t wr_data,
    input  logic                        fifo_full
);

    import vga_stream_pkg::*;

    localparam logic [7:0] FLASH_CMD = `FLASH_CMD_QREAD;
    localparam logic [4:0] CMD_LAST  = 5'd7;   // 8 command bits
    localparam logic [4:0] ADDR_LAST = 5'd23;  // 24 address bits
    localparam logic [4:0] NIB_LAST  = 5'd5;   // 6 nibbles per word

    qspi_state_t state;
    logic [4:0]  cnt;        // Bits, dummy periods or nibbles left
    logic [1:0]  gap_cnt;    // Chip select high time after restart
    logic        sclk_q;
    logic        cs_n_q;
    logic        wr_req_q;
    flash_word_t in_sr;
    logic        sample;

    // Nibble captured on the rising SCLK edge, unless back-pressured
    assign sample = (state == ST_DATA) && !sclk_q && !fifo_full;

    assign spi_sclk   = sclk_q;
    assign spi_cs_n   = cs_n_q;
    assign spi_io_out = {3'b000, (state == ST_CMD) ? FLASH_CMD[cnt[2:0]] : 1'b0};  // MSB first
    assign spi_io_oe  = (state == ST_CMD || state == ST_ADDR) ? 4'b0001 : 4'b0000;
    assign wr_req     = wr_req_q;
    assign wr_data    = in_sr;  // Stable while in handoff

    always_ff @(posedge clk) begin
        if (sample) begin
            in_sr <= {in_sr[19:0], spi_io_in};
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= ST_IDLE;
            cnt      <= '0;
            gap_cnt  <= '0;
            sclk_q   <= 1'b0;
            cs_n_q   <= 1'b1;
            wr_req_q <= 1'b0;
        end else if (restart) begin
            state    <= ST_IDLE;  // Abort whatever is in flight
            gap_cnt  <= 2'd2;
            sclk_q   <= 1'b0;
            cs_n_q   <= 1'b1;
            wr_req_q <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (gap_cnt != 2'd0) begin
                        gap_cnt <= gap_cnt - 2'd1;
                    end
                    if (gap_cnt == 2'd1) begin
                        cs_n_q <= 1'b0;
                        cnt    <= CMD_LAST;
                        state  <= ST_CMD;
                    end
                end
                ST_CMD: begin
                    sclk_q <= !sclk_q;
                    if (sclk_q) begin
                        cnt <= (cnt == 5'd0) ? ADDR_LAST : cnt - 5'd1;
                        if (cnt == 5'd0) state <= ST_ADDR;
                    end
                end
                ST_ADDR: begin
                    sclk_q <= !sclk_q;
                    if (sclk_q) begin
                        cnt <= (cnt == 5'd0) ? {1'b0, dummy_cycles} - 5'd1 : cnt - 5'd1;
                        if (cnt == 5'd0) state <= ST_DUMMY;
                    end
                end
                ST_DUMMY: begin
                    sclk_q <= !sclk_q;  // IO lines released, flash turns the bus around
                    if (sclk_q) begin
                        cnt <= (cnt == 5'd0) ? NIB_LAST : cnt - 5'd1;
                        if (cnt == 5'd0) state <= ST_DATA;
                    end
                end
                ST_DATA: begin
                    if (sclk_q) begin
                        sclk_q <= 1'b0;
                        if (cnt == 5'd0) begin
                            wr_req_q <= 1'b1;
                            state    <= ST_HANDOFF;
                        end else begin
                            cnt <= cnt - 5'd1;
                        end
                    end else if (!fifo_full) begin
                        sclk_q <= 1'b1;  // SCLK parked low while full
                    end
                end
                ST_HANDOFF: begin
                    if (wr_req_q && wr_ack) begin
                        wr_req_q <= 1'b0;
                    end else if (!wr_req_q && !wr_ack) begin
                        cnt   <= NIB_LAST;
                        state <= ST_DATA;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

//--- hw/instr_fifo.sv
// Four-entry instruction FIFO with a req/ack write side and flush
`include "vga_stream_defines.svh"

module instr_fifo (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        flush,
    input  logic                        wr_req,
    output logic                        wr_ack,
    input  vga_stream_pkg::flash_word_t wr_data,
    output logic                        full,
    output logic                        rd_valid,
    output vga_stream_pkg::instr_t      rd_data,
    input  logic                        rd_pop
);

    import vga_stream_pkg::*;

    localparam int PTR_W = $clog2(`FIFO_DEPTH);
    localparam int CNT_W = $clog2(`FIFO_DEPTH + 1);

    instr_t             mem [`FIFO_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               push;
    logic               pop;

    assign full     = (count == CNT_W'(`FIFO_DEPTH));
    assign rd_valid = (count != '0);
    assign rd_data  = mem[rd_ptr];
    assign push     = wr_req && !wr_ack && !full && !flush;  // Once per req phase
    assign pop      = rd_pop && rd_valid && !flush;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_data[17:0];  // Top 6 bits dropped
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            wr_ack <= 1'b0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            wr_ack <= 1'b0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            count <= count + CNT_W'(push) - CNT_W'(pop);
            if (push) begin
                wr_ack <= 1'b1;
            end else if (!wr_req) begin
                wr_ack <= 1'b0;  // Req gone, close the handshake
            end
        end
    end

endmodule

//--- hw/pixel_decoder.sv
// Run-length instruction decoder producing one colour per pixel request
module pixel_decoder (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    flush,
    input  logic                    pixel_req,
    input  logic                    line_start,
    input  logic                    rd_valid,
    input  vga_stream_pkg::instr_t  rd_data,
    output logic                    rd_pop,
    output vga_stream_pkg::colour_t colour
);

    import vga_stream_pkg::*;

    instr_t   cur;        // Instruction being drawn
    logic     cur_valid;
    run_len_t remain;     // Pixels left after the current one
    logic     cur_eol;
    logic     finish;

    assign cur_eol = cur[17];

    // A run ends on its last pixel, an EOL fill at the line boundary
    assign finish = cur_valid &&
                    ((pixel_req && !cur_eol && remain == '0) || (line_start && cur_eol));

    // Fetch when empty or on the clock the current run ends
    assign rd_pop = rd_valid && !flush && (!cur_valid || finish);

    always_ff @(posedge clk) begin
        if (rd_pop) begin
            cur <= rd_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cur_valid <= 1'b0;
            remain    <= '0;
            colour    <= '0;
        end else if (flush) begin
            cur_valid <= 1'b0;
            colour    <= '0;
        end else begin
            if (pixel_req) begin
                colour <= cur_valid ? cur[7:0] : '0;  // Underflow shows black
            end
            if (rd_pop) begin
                cur_valid <= 1'b1;
                remain    <= rd_data[16:8];
            end else if (finish) begin
                cur_valid <= 1'b0;
            end else if (pixel_req && cur_valid && !cur_eol) begin
                remain <= remain - 1'b1;
            end
        end
    end

endmodule

//--- hw/vga_timing.sv
// VGA 640x480 counters, registered syncs, pixel request and colour blanking
`include "vga_stream_defines.svh"

module vga_timing (
    input  logic                    clk,
    input  logic                    arst_n,
    input  vga_stream_pkg::colour_t colour_in,
    output logic                    pixel_req,
    output logic                    line_start,
    output logic                    vsync_start,
    output logic                    hsync,
    output logic                    vsync,
    output logic [2:0]              red,
    output logic [2:0]              green,
    output logic [1:0]              blue
);

    localparam logic [9:0] H_VIS     = 10'(`H_VISIBLE);
    localparam logic [9:0] H_SYNC_LO = 10'(`H_VISIBLE + `H_FRONT);
    localparam logic [9:0] H_SYNC_HI = 10'(`H_VISIBLE + `H_FRONT + `H_SYNC);
    localparam logic [9:0] H_LAST    = 10'(`H_TOTAL - 1);
    localparam logic [9:0] V_VIS     = 10'(`V_VISIBLE);
    localparam logic [9:0] V_SYNC_LO = 10'(`V_VISIBLE + `V_FRONT);
    localparam logic [9:0] V_SYNC_HI = 10'(`V_VISIBLE + `V_FRONT + `V_SYNC);
    localparam logic [9:0] V_LAST    = 10'(`V_TOTAL - 1);

    logic [9:0] h_cnt;
    logic [9:0] v_cnt;
    logic       active_q;  // Visible area, aligned with the decoder colour

    assign pixel_req  = (h_cnt < H_VIS) && (v_cnt < V_VIS);
    assign line_start = (h_cnt == H_VIS) && (v_cnt < V_VIS);  // After the last visible pixel

    assign red   = active_q ? colour_in[2:0] : 3'b000;
    assign green = active_q ? colour_in[5:3] : 3'b000;
    assign blue  = active_q ? colour_in[7:6] : 2'b00;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            h_cnt       <= '0;
            v_cnt       <= '0;
            hsync       <= 1'b1;
            vsync       <= 1'b1;
            vsync_start <= 1'b0;
            active_q    <= 1'b0;
        end else begin
            if (h_cnt == H_LAST) begin
                h_cnt <= '0;
                v_cnt <= (v_cnt == V_LAST) ? 10'd0 : v_cnt + 10'd1;
            end else begin
                h_cnt <= h_cnt + 10'd1;
            end
            hsync       <= !((h_cnt >= H_SYNC_LO) && (h_cnt < H_SYNC_HI));
            vsync       <= !((v_cnt >= V_SYNC_LO) && (v_cnt < V_SYNC_HI));
            vsync_start <= (v_cnt == V_SYNC_LO) && (h_cnt == 10'd0);  // First vsync low clock
            active_q    <= pixel_req;
        end
    end

endmodule

//--- hw/vga_stream_top.sv
// Top level of the flash-fed VGA pixel engine
module vga_stream_top (
    input  logic                     clk,
    input  logic                     arst_n,
    input  vga_stream_pkg::latency_t latency,
    input  logic [3:0]               spi_io_in,
    output logic                     spi_sclk,
    output logic                     spi_cs_n,
    output logic [3:0]               spi_io_out,
    output logic [3:0]               spi_io_oe,
    output logic                     hsync,
    output logic                     vsync,
    output logic [2:0]               red,
    output logic [2:0]               green,
    output logic [1:0]               blue
);

    import vga_stream_pkg::*;

    logic        restart;
    dummy_t      dummy_cycles;
    logic        vsync_start;
    logic        wr_req;
    logic        wr_ack;
    flash_word_t wr_data;
    logic        fifo_full;
    logic        rd_valid;
    instr_t      rd_data;
    logic        rd_pop;
    logic        pixel_req;
    logic        line_start;
    colour_t     colour;

    stream_ctrl stream_ctrl_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .latency      (latency),
        .vsync_start  (vsync_start),
        .restart      (restart),
        .dummy_cycles (dummy_cycles)
    );

    qspi_reader qspi_reader_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .restart      (restart),
        .dummy_cycles (dummy_cycles),
        .spi_sclk     (spi_sclk),
        .spi_cs_n     (spi_cs_n),
        .spi_io_out   (spi_io_out),
        .spi_io_oe    (spi_io_oe),
        .spi_io_in    (spi_io_in),
        .wr_req       (wr_req),
        .wr_ack       (wr_ack),
        .wr_data      (wr_data),
        .fifo_full    (fifo_full)
    );

    instr_fifo instr_fifo_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .flush    (restart),  // Drop stale words each frame
        .wr_req   (wr_req),
        .wr_ack   (wr_ack),
        .wr_data  (wr_data),
        .full     (fifo_full),
        .rd_valid (rd_valid),
        .rd_data  (rd_data),
        .rd_pop   (rd_pop)
    );

    pixel_decoder pixel_decoder_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .flush      (restart),
        .pixel_req  (pixel_req),
        .line_start (line_start),
        .rd_valid   (rd_valid),
        .rd_data    (rd_data),
        .rd_pop     (rd_pop),
        .colour     (colour)
    );

    vga_timing vga_timing_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .colour_in   (colour),
        .pixel_req   (pixel_req),
        .line_start  (line_start),
        .vsync_start (vsync_start),
        .hsync       (hsync),
        .vsync       (vsync),
        .red         (red),
        .green       (green),
        .blue        (blue)
    );

endmodule

//--- dv/vga_stream_sva.sv
// Bound assertions on the FIFO handshake, hsync width and chip select at restart
`include "vga_stream_defines.svh"

module vga_stream_sva (
    input logic clk,
    input logic arst_n,
    input logic restart,
    input logic wr_req,
    input logic wr_ack,
    input logic hsync,
    input logic spi_cs_n
);

    int fail_count = 0;  // Failed assertions so far

    // Req rises only with ack low, ack falls only with req low
    assert property (@(posedge clk) disable iff (!arst_n) $rose(wr_req) |-> !wr_ack)
        else begin
            fail_count++;
            $error("wr_req rose while wr_ack high");
        end
    assert property (@(posedge clk) disable iff (!arst_n) $fell(wr_ack) |-> !wr_req)
        else begin
            fail_count++;
            $error("wr_ack fell while wr_req high");
        end
    assert property (@(posedge clk) disable iff (!arst_n)
        $fell(wr_req) |-> ($past(wr_ack) || $past(restart)))
        else begin
            fail_count++;
            $error("wr_req fell without wr_ack");
        end

    assert property (@(posedge clk) disable iff (!arst_n)
        $fell(hsync) |=> !hsync [*(`H_SYNC - 1)] ##1 hsync)
        else begin
            fail_count++;
            $error("hsync low width wrong");
        end

    // Flash deselected for at least two clocks
    assert property (@(posedge clk) disable iff (!arst_n) restart |=> spi_cs_n [*2])
        else begin
            fail_count++;
            $error("spi_cs_n not high after restart");
        end

endmodule

bind vga_stream_top vga_stream_sva vga_stream_sva_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .restart  (restart),
    .wr_req   (wr_req),
    .wr_ack   (wr_ack),
    .hsync    (hsync),
    .spi_cs_n (spi_cs_n)
);

//--- dv/tb_vga_stream.sv
// Testbench with a quad flash model, pixel and sync checker, timeout and error counts
`include "vga_stream_defines.svh"

module tb_vga_stream;

    localparam int FRAME_CLKS = `H_TOTAL * `V_TOTAL;
    localparam int NPIX       = `H_VISIBLE * `V_VISIBLE;
    localparam int END_TICK   = 2 * FRAME_CLKS + 20 * `H_TOTAL;  // Image lines of frame 2
    localparam int LIMIT      = (21 * FRAME_CLKS) / 10;  // Two frames and a tenth
    localparam int SWITCH_AT  = FRAME_CLKS + 100 * `H_TOTAL;

    logic       clk;
    logic       arst_n;
    logic [1:0] latency;
    logic [3:0] spi_io_in;
    logic       spi_sclk;
    logic       spi_cs_n;
    logic [3:0] spi_io_out;
    logic [3:0] spi_io_oe;
    logic       hsync;
    logic       vsync;
    logic [2:0] red;
    logic [2:0] green;
    logic [1:0] blue;

    logic [23:0] vec [0:63];
    logic [7:0]  exp_pix [0:NPIX-1];
    int          n_instr;
    logic [1:0]  lat1;
    logic [1:0]  lat2;
    int          tick;
    int          pixel_errs;
    int          sync_errs;
    int          proto_errs;
    int          transfers;

    // Flash model state
    int          rises;
    int          ptr;
    int          exp_dummy;
    logic [31:0] cmd_sr;
    logic        cs_prev;
    logic        sclk_prev;
    logic        first_pending;

    vga_stream_top vga_stream_top_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .latency    (latency),
        .spi_io_in  (spi_io_in),
        .spi_sclk   (spi_sclk),
        .spi_cs_n   (spi_cs_n),
        .spi_io_out (spi_io_out),
        .spi_io_oe  (spi_io_oe),
        .hsync      (hsync),
        .vsync      (vsync),
        .red        (red),
        .green      (green),
        .blue       (blue)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [23:0] flash_word(int k);
        return (k < n_instr) ? vec[2 + 2 * k] : 24'h0;  // Erased tail reads as zero
    endfunction

    function automatic logic [3:0] flash_nibble(int p);
        logic [23:0] w;
        w = flash_word(p / 6);
        return w[23 - 4 * (p % 6) -: 4];
    endfunction

    // Expand the runs into one colour per visible pixel
    task automatic build_expected();
        int          idx;
        int          remain;
        logic        have;
        logic        eol;
        logic [7:0]  col;
        logic [23:0] w;
        idx  = 0;
        have = 1'b0;
        eol  = 1'b0;
        col  = '0;
        remain = 0;
        for (int i = 0; i < n_instr; i++) begin
            if (vec[2 + 2 * i][7:0] != vec[3 + 2 * i][7:0]) begin
                $display("vector line %0d: colour column disagrees with flash word", i);
                proto_errs++;
            end
        end
        for (int y = 0; y < `V_VISIBLE; y++) begin
            for (int x = 0; x < `H_VISIBLE; x++) begin
                if (!have && idx < n_instr) begin
                    w = flash_word(idx);
                    idx++;
                    have = 1'b1;
                    eol = w[17];
                    remain = int'(w[16:8]);
                    col = w[7:0];
                end
                exp_pix[y * `H_VISIBLE + x] = have ? col : 8'h00;
                if (have && !eol) begin
                    if (remain == 0) have = 1'b0;
                    else remain--;
                end
            end
            // A fill picked up right at the line end is closed by the same line end
            if (!have && idx < n_instr) begin
                w = flash_word(idx);
                idx++;
                have = 1'b1;
                eol = w[17];
                remain = int'(w[16:8]);
                col = w[7:0];
            end
            if (have && eol) have = 1'b0;
        end
    endtask

    always @(posedge clk) begin
        if (arst_n) tick <= tick + 1;
    end

    // Behavioral quad flash, edges of SCLK seen on the falling clock
    always @(negedge clk) begin
        if (!arst_n) begin
            rises = 0;
            ptr = 0;
        end else if (spi_cs_n) begin
            rises = 0;
            ptr = 0;
        end else begin
            if (cs_prev) begin
                exp_dummy = `DUMMY_BASE + 2 * int'(latency);
                cmd_sr = '0;
                first_pending = 1'b1;
            end
            if (spi_sclk && !sclk_prev) begin
                if (rises < 32) begin
                    if (spi_io_oe != 4'b0001) begin
                        $display("mismatch spi_io_oe in command/address: got %h exp %h",
                                 spi_io_oe, 4'b0001);
                        proto_errs++;
                    end
                    cmd_sr = {cmd_sr[30:0], spi_io_out[0]};
                end
                rises++;
                if (rises == 32 && cmd_sr != {`FLASH_CMD_QREAD, 24'h0}) begin
                    $display("mismatch spi_io_out[0] command/address: got %h exp %h", cmd_sr,
                             {`FLASH_CMD_QREAD, 24'h0});
                    proto_errs++;
                end
            end
            if (!spi_sclk && sclk_prev && rises >= 32 + exp_dummy) begin
                spi_io_in <= flash_nibble(ptr);
                ptr++;
            end
            if (first_pending && vga_stream_top_i.wr_req) begin
                first_pending = 1'b0;
                transfers++;
                if (vga_stream_top_i.wr_data != flash_word(0)) begin
                    $display("mismatch wr_data first word: got %h exp %h, dummy count %0d",
                             vga_stream_top_i.wr_data, flash_word(0), exp_dummy);
                    proto_errs++;
                end
            end
        end
        cs_prev = spi_cs_n;
        sclk_prev = spi_sclk;
    end

    // Sync and pixel checker against a counter started at reset release
    always @(negedge clk) begin
        int n;
        int h;
        int v;
        int f;
        logic       hs_exp;
        logic       vs_exp;
        logic [7:0] got;
        logic [7:0] want;
        got = {blue, green, red};
        if (!arst_n) begin
            if (!spi_cs_n || !hsync || !vsync || got != 8'h00) begin
                $display("mismatch outputs in reset: spi_cs_n %h hsync %h vsync %h rgb %h",
                         spi_cs_n, hsync, vsync, got);
                sync_errs++;
            end
        end else if (tick > 0) begin
            n = tick - 1;
            h = n % `H_TOTAL;
            v = (n / `H_TOTAL) % `V_TOTAL;
            f = n / FRAME_CLKS;
            hs_exp = !(h >= `H_VISIBLE + `H_FRONT && h < `H_VISIBLE + `H_FRONT + `H_SYNC);
            vs_exp = !(v >= `V_VISIBLE + `V_FRONT && v < `V_VISIBLE + `V_FRONT + `V_SYNC);
            if (hsync != hs_exp) begin
                $display("mismatch hsync at h %0d: got %h exp %h", h, hsync, hs_exp);
                sync_errs++;
            end
            if (vsync != vs_exp) begin
                $display("mismatch vsync at v %0d: got %h exp %h", v, vsync, vs_exp);
                sync_errs++;
            end
            if (h < `H_VISIBLE && v < `V_VISIBLE) begin
                if (f >= 1) begin
                    want = exp_pix[v * `H_VISIBLE + h];
                    if (got != want) begin
                        if (pixel_errs < 20)
                            $display("mismatch rgb frame %0d x %0d y %0d: got %h exp %h",
                                     f, h, v, got, want);
                        pixel_errs++;
                    end
                end
            end else if (got != 8'h00) begin
                $display("mismatch rgb in blanking h %0d v %0d: got %h exp 00", h, v, got);
                pixel_errs++;
            end
        end
    end

    always @(posedge clk) begin
        if (tick >= LIMIT) begin
            $display("timeout after %0d cycles", tick);
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin
        int seed_ret;
        int assert_errs;
        seed_ret = $urandom(36733);
        arst_n = 1'b0;
        spi_io_in = 4'h0;
        tick = 0;
        pixel_errs = 0;
        sync_errs = 0;
        proto_errs = 0;
        transfers = 0;
        cs_prev = 1'b1;
        sclk_prev = 1'b0;
        first_pending = 1'b0;
        exp_dummy = `DUMMY_BASE;
        cmd_sr = '0;
        $readmemh("dv/stream_vectors.hex", vec);
        lat1 = vec[0][1:0];
        n_instr = int'(vec[1]);
        lat2 = 2'((int'(lat1) + 1 + ($urandom % 3)) % 4);  // Differs from frame 1
        latency = lat1;
        build_expected();
        repeat (4) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        while (tick < SWITCH_AT) @(negedge clk);
        latency = lat2;  // Latched at the next vsync for frame 2
        while (tick < END_TICK) @(negedge clk);
        if (transfers < 3) begin
            $display("only %0d flash transfers delivered a word, 3 expected", transfers);
            proto_errs++;
        end
        assert_errs = vga_stream_top_i.vga_stream_sva_i.fail_count;
        $display("errors: pixel %0d sync %0d protocol %0d assertion %0d", pixel_errs,
                 sync_errs, proto_errs, assert_errs);
        if (pixel_errs + sync_errs + proto_errs + assert_errs == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+hw
hw/vga_stream_pkg.sv
hw/stream_ctrl.sv
hw/qspi_reader.sv
hw/instr_fifo.sv
hw/pixel_decoder.sv
hw/vga_timing.sv
hw/vga_stream_top.sv
dv/vga_stream_sva.sv
dv/tb_vga_stream.sv

//--- Makefile
# Verilator lint, simulation and clean for the VGA stream engine

VERILATOR ?= verilator
TOP       ?= tb_vga_stream
RTL_TOP   ?= vga_stream_top
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Testbench failed" $(LOG); then exit 1; fi
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/stream_vectors.hex
// Line 1: latency setting, instruction count
// Other lines: 24-bit flash word, expected colour
1 10
00C7E0 E0
152B1C 1C
020003 03
FE05FF FF
01FF25 25
007F92 92
018F49 49
02006D 6D
003F11 11
003F22 22
003F33 33
003F44 44
003F55 55
02000A 0A
01F3C3 C3
012B3C 3C
